//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    //////////////////////////////////////////////////
    // widths
    localparam int xlen    = 32;
    localparam int inst_w  = 32;
    // shifts only look at the low bits of operand b
    localparam int shamt_w = 5;

    //////////////////////////////////////////////////
    // operation and operand select codes

    // alu and mult codes share one space
    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_mul,
        alu_mulh,
        alu_mulhsu,
        alu_mulhu
    } alu_func_e;

    typedef enum logic [1:0] {
        opa_is_rs1,
        opa_is_npc,
        opa_is_pc,
        opa_is_zero
    } opa_sel_e;

    // codes 6 and 7 unused
    typedef enum logic [2:0] {
        opb_is_rs2,
        opb_is_i_imm,
        opb_is_s_imm,
        opb_is_b_imm,
        opb_is_u_imm,
        opb_is_j_imm
    } opb_sel_e;

    // markers seen on a result when a select or code is bad
    localparam logic [xlen-1:0] bad_opa_value  = 32'hdeadfbac;
    localparam logic [xlen-1:0] bad_opb_value  = 32'hfacefeed;
    localparam logic [xlen-1:0] bad_func_value = 32'hfacebeec;

    //////////////////////////////////////////////////
    // immediate extraction, all sign extended from bit 31

    function automatic logic [xlen-1:0] imm_i(input logic [inst_w-1:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [xlen-1:0] imm_s(input logic [inst_w-1:0] inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    // branch offset, bit 0 always zero
    function automatic logic [xlen-1:0] imm_b(input logic [inst_w-1:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    // upper immediate, low 12 bits zero
    function automatic logic [xlen-1:0] imm_u(input logic [inst_w-1:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

    // jal offset
    function automatic logic [xlen-1:0] imm_j(input logic [inst_w-1:0] inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

//--- hdl/fu_pkg.sv
package fu_pkg;

    //////////////////////////////////////////////////
    // pass-through identifier widths
    localparam int tag_w     = 6;
    localparam int rob_idx_w = 5;
    localparam int thread_w  = 1;

    //////////////////////////////////////////////////
    // issue side to unit

    typedef struct packed {
        logic                                valid;
        logic [rv_isa_pkg::inst_w-1:0]       inst;
        logic [rv_isa_pkg::xlen-1:0]         pc;
        logic [rv_isa_pkg::xlen-1:0]         npc;
        logic [rv_isa_pkg::xlen-1:0]         rs1_value;
        logic [rv_isa_pkg::xlen-1:0]         rs2_value;
        rv_isa_pkg::opa_sel_e                opa_sel;
        rv_isa_pkg::opb_sel_e                opb_sel;
        rv_isa_pkg::alu_func_e               func;
        // branch kind, only the branch unit looks at these
        logic                                cond_br;
        logic                                uncond_br;
        logic [tag_w-1:0]                    tag;
        logic [rob_idx_w-1:0]                rob_idx;
        logic [thread_w-1:0]                 thread_idx;
    } fu_issue_t;

    //////////////////////////////////////////////////
    // unit to broadcast side

    typedef struct packed {
        logic                                valid;
        logic [rv_isa_pkg::xlen-1:0]         pc;
        // set for alu and mult results
        logic                                write_reg;
        logic [rv_isa_pkg::xlen-1:0]         rd_value;
        logic [tag_w-1:0]                    tag;
        // branch outcome, zero outside the branch unit
        logic                                br_inst;
        logic                                br_result;
        logic [rv_isa_pkg::xlen-1:0]         br_target;
        logic [thread_w-1:0]                 thread_idx;
        logic [rob_idx_w-1:0]                rob_idx;
    } fu_result_t;

endpackage

//--- hdl/operand_mux.sv
`timescale 1ns/1ps

module operand_mux (
    input  fu_pkg::fu_issue_t            issue_i,
    output logic [rv_isa_pkg::xlen-1:0]  opa_o,
    output logic [rv_isa_pkg::xlen-1:0]  opb_o
);
    import rv_isa_pkg::*;

    //////////////////////////////////////////////////
    // operand a

    always_comb begin
        case (issue_i.opa_sel)
            opa_is_rs1:  opa_o = issue_i.rs1_value;
            // link value for jal and jalr
            opa_is_npc:  opa_o = issue_i.npc;
            // auipc and branch targets
            opa_is_pc:   opa_o = issue_i.pc;
            // lui
            opa_is_zero: opa_o = '0;
            default:     opa_o = bad_opa_value;
        endcase
    end

    //////////////////////////////////////////////////
    // operand b

    always_comb begin
        case (issue_i.opb_sel)
            opb_is_rs2:   opb_o = issue_i.rs2_value;
            // immediates decoded straight from the captured word
            opb_is_i_imm: opb_o = imm_i(issue_i.inst);
            opb_is_s_imm: opb_o = imm_s(issue_i.inst);
            opb_is_b_imm: opb_o = imm_b(issue_i.inst);
            opb_is_u_imm: opb_o = imm_u(issue_i.inst);
            opb_is_j_imm: opb_o = imm_j(issue_i.inst);
            // codes 6 and 7
            default:      opb_o = bad_opb_value;
        endcase
    end

endmodule

//--- hdl/alu_core.sv
`timescale 1ns/1ps

module alu_core (
    input  logic [rv_isa_pkg::xlen-1:0]  opa_i,
    input  logic [rv_isa_pkg::xlen-1:0]  opb_i,
    input  rv_isa_pkg::alu_func_e        func_i,
    output logic [rv_isa_pkg::xlen-1:0]  result_o
);
    import rv_isa_pkg::*;

    // signed views for slt and sra
    logic signed [xlen-1:0] opa_s;
    logic signed [xlen-1:0] opb_s;
    logic [shamt_w-1:0]     shamt;

    assign opa_s = opa_i;
    assign opb_s = opb_i;
    assign shamt = opb_i[shamt_w-1:0];

    always_comb begin
        case (func_i)
            alu_add:  result_o = opa_i + opb_i;
            alu_sub:  result_o = opa_i - opb_i;
            alu_and:  result_o = opa_i & opb_i;
            alu_or:   result_o = opa_i | opb_i;
            alu_xor:  result_o = opa_i ^ opb_i;
            // compares give 0 or 1
            alu_slt:  result_o = {{(xlen-1){1'b0}}, opa_s < opb_s};
            alu_sltu: result_o = {{(xlen-1){1'b0}}, opa_i < opb_i};
            alu_sll:  result_o = opa_i << shamt;
            alu_srl:  result_o = opa_i >> shamt;
            // sign bit fills from the left
            alu_sra:  result_o = opa_s >>> shamt;
            // mult codes land here too
            default:  result_o = bad_func_value;
        endcase
    end

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit #(
    parameter int lat = 1
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  fu_pkg::fu_issue_t   issue_i,
    input  logic                ack_i,
    output logic                ready_o,
    output fu_pkg::fu_result_t  result_o
);
    import rv_isa_pkg::*;
    import fu_pkg::*;

    // counter has to hold the value lat
    localparam int cnt_w = $clog2(lat + 1);

    fu_issue_t         iss_q;
    logic              busy_q;
    logic [cnt_w-1:0]  cnt_q;
    logic [xlen-1:0]   opa;
    logic [xlen-1:0]   opb;
    logic [xlen-1:0]   rd_value;

    // datapath works off the held packet
    operand_mux u_opmux (
        .issue_i (iss_q),
        .opa_o   (opa),
        .opb_o   (opb)
    );

    alu_core u_alu (
        .opa_i    (opa),
        .opb_i    (opb),
        .func_i   (iss_q.func),
        .result_o (rd_value)
    );

    //////////////////////////////////////////////////
    // capture, count, result, release

    always_ff @(posedge clk_i) begin
        // ack frees the slot, also drops an op still in flight
        if (!rst_n_i || ack_i) begin
            busy_q         <= 1'b0;
            cnt_q          <= '0;
            ready_o        <= 1'b1;
            result_o.valid <= 1'b0;
        end else if (ready_o && issue_i.valid) begin
            busy_q  <= 1'b1;
            cnt_q   <= '0;
            ready_o <= 1'b0;
            iss_q   <= issue_i;
        end else if (busy_q && (cnt_q != cnt_w'(lat))) begin
            cnt_q <= cnt_q + 1'b1;
        end else if (busy_q) begin
            // latency done, freeze the packet until ack
            busy_q               <= 1'b0;
            result_o.valid       <= 1'b1;
            result_o.pc          <= iss_q.pc;
            result_o.write_reg   <= 1'b1;
            result_o.rd_value    <= rd_value;
            result_o.tag         <= iss_q.tag;
            result_o.br_inst     <= 1'b0;
            result_o.br_result   <= 1'b0;
            result_o.br_target   <= '0;
            result_o.thread_idx  <= iss_q.thread_idx;
            result_o.rob_idx     <= iss_q.rob_idx;
        end
    end

endmodule

//--- hdl/mult_unit.sv
`timescale 1ns/1ps

module mult_unit #(
    parameter int lat = 3
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  fu_pkg::fu_issue_t   issue_i,
    input  logic                ack_i,
    output logic                ready_o,
    output fu_pkg::fu_result_t  result_o
);
    import rv_isa_pkg::*;
    import fu_pkg::*;

    localparam int cnt_w  = $clog2(lat + 1);
    localparam int prod_w = 2 * xlen;

    fu_issue_t          iss_q;
    logic               busy_q;
    logic [cnt_w-1:0]   cnt_q;
    logic [xlen-1:0]    opa;
    logic [xlen-1:0]    opb;
    logic [prod_w-1:0]  prod_ss;
    logic [prod_w-1:0]  prod_su;
    logic [prod_w-1:0]  prod_uu;
    logic [xlen-1:0]    rd_value;

    operand_mux u_opmux (
        .issue_i (iss_q),
        .opa_o   (opa),
        .opb_o   (opb)
    );

    //////////////////////////////////////////////////
    // products
    // operands widened by hand, low 64 bits are exact for every sign mix
    assign prod_ss = {{xlen{opa[xlen-1]}}, opa} * {{xlen{opb[xlen-1]}}, opb};
    assign prod_su = {{xlen{opa[xlen-1]}}, opa} * {{xlen{1'b0}}, opb};
    assign prod_uu = {{xlen{1'b0}}, opa} * {{xlen{1'b0}}, opb};

    // mul takes the low half, the rest the high half
    always_comb begin
        case (iss_q.func)
            alu_mul:    rd_value = prod_ss[xlen-1:0];
            alu_mulh:   rd_value = prod_ss[prod_w-1:xlen];
            alu_mulhsu: rd_value = prod_su[prod_w-1:xlen];
            alu_mulhu:  rd_value = prod_uu[prod_w-1:xlen];
            default:    rd_value = bad_func_value;
        endcase
    end

    //////////////////////////////////////////////////
    // same sequencing as the alu slot

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || ack_i) begin
            busy_q         <= 1'b0;
            cnt_q          <= '0;
            ready_o        <= 1'b1;
            result_o.valid <= 1'b0;
        end else if (ready_o && issue_i.valid) begin
            busy_q  <= 1'b1;
            cnt_q   <= '0;
            ready_o <= 1'b0;
            iss_q   <= issue_i;
        end else if (busy_q && (cnt_q != cnt_w'(lat))) begin
            cnt_q <= cnt_q + 1'b1;
        end else if (busy_q) begin
            busy_q               <= 1'b0;
            result_o.valid       <= 1'b1;
            result_o.pc          <= iss_q.pc;
            result_o.write_reg   <= 1'b1;
            result_o.rd_value    <= rd_value;
            result_o.tag         <= iss_q.tag;
            result_o.br_inst     <= 1'b0;
            result_o.br_result   <= 1'b0;
            result_o.br_target   <= '0;
            result_o.thread_idx  <= iss_q.thread_idx;
            result_o.rob_idx     <= iss_q.rob_idx;
        end
    end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit #(
    parameter int lat = 1
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  fu_pkg::fu_issue_t   issue_i,
    input  logic                ack_i,
    output logic                ready_o,
    output fu_pkg::fu_result_t  result_o
);
    import rv_isa_pkg::*;
    import fu_pkg::*;

    localparam int cnt_w = $clog2(lat + 1);

    fu_issue_t               iss_q;
    logic                    busy_q;
    logic [cnt_w-1:0]        cnt_q;
    logic [xlen-1:0]         opa;
    logic [xlen-1:0]         opb;
    logic [xlen-1:0]         br_target;
    logic [2:0]              funct3;
    logic signed [xlen-1:0]  rs1_s;
    logic signed [xlen-1:0]  rs2_s;
    logic                    cond;
    logic                    taken;

    operand_mux u_opmux (
        .issue_i (iss_q),
        .opa_o   (opa),
        .opb_o   (opb)
    );

    // target comes from the normal alu path, usually pc + b_imm
    alu_core u_target (
        .opa_i    (opa),
        .opb_i    (opb),
        .func_i   (iss_q.func),
        .result_o (br_target)
    );

    //////////////////////////////////////////////////
    // condition on rs1 and rs2, picked by funct3
    assign funct3 = iss_q.inst[14:12];
    assign rs1_s  = iss_q.rs1_value;
    assign rs2_s  = iss_q.rs2_value;

    always_comb begin
        case (funct3)
            3'b000:  cond = iss_q.rs1_value == iss_q.rs2_value;
            3'b001:  cond = iss_q.rs1_value != iss_q.rs2_value;
            3'b100:  cond = rs1_s < rs2_s;
            3'b101:  cond = rs1_s >= rs2_s;
            3'b110:  cond = iss_q.rs1_value < iss_q.rs2_value;
            3'b111:  cond = iss_q.rs1_value >= iss_q.rs2_value;
            // 010 and 011 are not branches
            default: cond = 1'b0;
        endcase
    end

    // jumps always taken
    assign taken = iss_q.uncond_br | (iss_q.cond_br & cond);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || ack_i) begin
            busy_q         <= 1'b0;
            cnt_q          <= '0;
            ready_o        <= 1'b1;
            result_o.valid <= 1'b0;
        end else if (ready_o && issue_i.valid) begin
            busy_q  <= 1'b1;
            cnt_q   <= '0;
            ready_o <= 1'b0;
            iss_q   <= issue_i;
        end else if (busy_q && (cnt_q != cnt_w'(lat))) begin
            cnt_q <= cnt_q + 1'b1;
        end else if (busy_q) begin
            // no register write from this slot
            busy_q               <= 1'b0;
            result_o.valid       <= 1'b1;
            result_o.pc          <= iss_q.pc;
            result_o.write_reg   <= 1'b0;
            result_o.rd_value    <= '0;
            result_o.tag         <= iss_q.tag;
            result_o.br_inst     <= 1'b1;
            result_o.br_result   <= taken;
            result_o.br_target   <= br_target;
            result_o.thread_idx  <= iss_q.thread_idx;
            result_o.rob_idx     <= iss_q.rob_idx;
        end
    end

endmodule

//--- hdl/fu_top.sv
`timescale 1ns/1ps

module fu_top #(
    parameter int   alu_num  = 2,
    parameter int   mult_num = 1,
    parameter int   br_num   = 1,
    parameter int   alu_lat  = 1,
    parameter int   mult_lat = 3,
    parameter int   br_lat   = 1,
    localparam int  slot_num = alu_num + mult_num + br_num
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  fu_pkg::fu_issue_t  [slot_num-1:0]    issue_i,
    input  logic               [slot_num-1:0]    ack_i,
    output logic               [slot_num-1:0]    ready_o,
    output fu_pkg::fu_result_t [slot_num-1:0]    result_o
);
    //////////////////////////////////////////////////
    // slot map, alu first then mult then branch
    localparam int alu_base  = 0;
    localparam int mult_base = alu_base + alu_num;
    localparam int br_base   = mult_base + mult_num;

    alu_unit #(.lat(alu_lat)) u_alu [alu_num-1:0] (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .issue_i  (issue_i[alu_base+alu_num-1:alu_base]),
        .ack_i    (ack_i[alu_base+alu_num-1:alu_base]),
        .ready_o  (ready_o[alu_base+alu_num-1:alu_base]),
        .result_o (result_o[alu_base+alu_num-1:alu_base])
    );

    mult_unit #(.lat(mult_lat)) u_mult [mult_num-1:0] (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .issue_i  (issue_i[mult_base+mult_num-1:mult_base]),
        .ack_i    (ack_i[mult_base+mult_num-1:mult_base]),
        .ready_o  (ready_o[mult_base+mult_num-1:mult_base]),
        .result_o (result_o[mult_base+mult_num-1:mult_base])
    );

    // branch slots sit at the top of the range
    branch_unit #(.lat(br_lat)) u_br [br_num-1:0] (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .issue_i  (issue_i[br_base+br_num-1:br_base]),
        .ack_i    (ack_i[br_base+br_num-1:br_base]),
        .ready_o  (ready_o[br_base+br_num-1:br_base]),
        .result_o (result_o[br_base+br_num-1:br_base])
    );

endmodule

//--- tests/fu_chk.sv
`timescale 1ns/1ps

module fu_chk (
    input logic clk_i,
    input logic rst_n_i,
    input logic ack_i,
    input logic ready_i,
    input logic valid_i,
    input logic busy_i
);
    //////////////////////////////////////////////////
    // handshake rules of an alu slot

    // a free slot holds no result
    valid_ready_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(valid_i && ready_i))
        else $error("valid and ready high together");

    // ack releases the result one edge later
    ack_drops_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> !valid_i)
        else $error("valid still high after ack");

    // no new issue while counting
    busy_blocks_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy_i |-> !ready_i)
        else $error("ready high while the counter runs");

endmodule

bind alu_unit fu_chk u_chk (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .ack_i   (ack_i),
    .ready_i (ready_o),
    .valid_i (result_o.valid),
    .busy_i  (busy_q)
);

//--- tests/fu_tb.sv
`timescale 1ns/1ps

module fu_tb;
    import rv_isa_pkg::*;
    import fu_pkg::*;

    //////////////////////////////////////////////////
    // bank shape and run limits
    localparam int alu_num    = 2;
    localparam int mult_num   = 1;
    localparam int br_num     = 1;
    localparam int alu_lat    = 1;
    localparam int mult_lat   = 3;
    localparam int br_lat     = 1;
    localparam int slot_num   = alu_num + mult_num + br_num;
    localparam int alu_ops    = 480;
    localparam int mult_ops   = 60;
    localparam int br_ops     = 84;
    localparam int wait_limit = 100;
    localparam logic [31:0] seed = 32'd70;

    // hold and ack states of the compare process
    localparam int st_idle = 0;
    localparam int st_hold = 1;
    localparam int st_ack  = 2;
    localparam int st_free = 3;

    localparam logic [31:0] extremes [5] = '{32'h8000_0000, 32'h7fff_ffff,
                                             32'hffff_ffff, 32'h0000_0000, 32'h0000_0001};
    // beq bne blt bge bltu bgeu
    localparam logic [2:0] br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic                           clk_i = 1'b0;
    logic                           rst_n_i = 1'b0;
    fu_issue_t  [slot_num-1:0]      issue_i = '0;
    logic       [slot_num-1:0]      ack_i = '0;
    logic       [slot_num-1:0]      ready_o;
    fu_result_t [slot_num-1:0]      result_o;

    int          cyc = 0;
    logic [31:0] stim_state = seed;
    logic [31:0] hold_state = seed;
    fu_issue_t   pkt_q [slot_num][$];
    fu_result_t  exp_q [slot_num][$];
    int          cap_q [slot_num][$];
    int          rd_idx [slot_num] = '{default: 0};
    int          state [slot_num] = '{default: 0};
    int          hold [slot_num] = '{default: 0};
    int          wait_cnt [slot_num] = '{default: 0};
    fu_result_t  seen [slot_num];

    fu_top #(
        .alu_num  (alu_num),
        .mult_num (mult_num),
        .br_num   (br_num),
        .alu_lat  (alu_lat),
        .mult_lat (mult_lat),
        .br_lat   (br_lat)
    ) i_dut (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .issue_i  (issue_i),
        .ack_i    (ack_i),
        .ready_o  (ready_o),
        .result_o (result_o)
    );

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    // cycle count moves on the falling edge
    always @(negedge clk_i) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    // 0 alu, 1 mult, 2 branch
    function automatic int slot_kind(input int s);
        return (s < alu_num) ? 0 : (s < alu_num + mult_num) ? 1 : 2;
    endfunction

    function automatic int slot_lat(input int s);
        return (s < alu_num) ? alu_lat : (s < alu_num + mult_num) ? mult_lat : br_lat;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            stop_with_failure("value check failed");
        end
    endtask

    //////////////////////////////////////////////////
    // expected result from the issue packet

    function automatic fu_result_t expected_result(input fu_issue_t p, input int kind);
        fu_result_t  r;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [63:0] ss;
        logic [63:0] su;
        logic [63:0] uu;
        logic        c;
        w = p.inst;
        case (p.opa_sel)
            opa_is_rs1: a = p.rs1_value;
            opa_is_npc: a = p.npc;
            opa_is_pc:  a = p.pc;
            default:    a = 32'h0;
        endcase
        // immediates straight from the instruction formats
        case (p.opb_sel)
            opb_is_rs2:   b = p.rs2_value;
            opb_is_i_imm: b = {{20{w[31]}}, w[31:20]};
            opb_is_s_imm: b = {{20{w[31]}}, w[31:25], w[11:7]};
            opb_is_b_imm: b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            opb_is_u_imm: b = {w[31:12], 12'h000};
            opb_is_j_imm: b = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:      b = bad_opb_value;
        endcase
        ss = longint'($signed(a)) * longint'($signed(b));
        su = longint'($signed(a)) * longint'({32'h0, b});
        uu = {32'h0, a} * {32'h0, b};
        case (p.func)
            alu_add:    v = a + b;
            alu_sub:    v = a - b;
            alu_and:    v = a & b;
            alu_or:     v = a | b;
            alu_xor:    v = a ^ b;
            alu_slt:    v = {31'h0, $signed(a) < $signed(b)};
            alu_sltu:   v = {31'h0, a < b};
            alu_sll:    v = a << b[4:0];
            alu_srl:    v = a >> b[4:0];
            alu_sra:    v = $signed(a) >>> b[4:0];
            alu_mul:    v = ss[31:0];
            alu_mulh:   v = ss[63:32];
            alu_mulhsu: v = su[63:32];
            alu_mulhu:  v = uu[63:32];
            default:    v = bad_func_value;
        endcase
        case (w[14:12])
            3'b000:  c = p.rs1_value == p.rs2_value;
            3'b001:  c = p.rs1_value != p.rs2_value;
            3'b100:  c = $signed(p.rs1_value) < $signed(p.rs2_value);
            3'b101:  c = $signed(p.rs1_value) >= $signed(p.rs2_value);
            3'b110:  c = p.rs1_value < p.rs2_value;
            3'b111:  c = p.rs1_value >= p.rs2_value;
            default: c = 1'b0;
        endcase
        r            = '0;
        r.valid      = 1'b1;
        r.pc         = p.pc;
        r.tag        = p.tag;
        r.rob_idx    = p.rob_idx;
        r.thread_idx = p.thread_idx;
        if (kind == 2) begin
            r.br_inst   = 1'b1;
            r.br_result = p.uncond_br | (p.cond_br & c);
            r.br_target = v;
        end else begin
            r.write_reg = 1'b1;
            r.rd_value  = v;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // stimulus

    function automatic fu_issue_t rand_packet();
        fu_issue_t p;
        p            = '0;
        p.inst       = next_rand();
        p.pc         = next_rand() & 32'hffff_fffc;
        p.npc        = p.pc + 32'd4;
        p.rs1_value  = next_rand();
        p.rs2_value  = next_rand();
        // identifiers from the upper lcg bits
        p.tag        = tag_w'(next_rand() >> (32 - tag_w));
        p.rob_idx    = rob_idx_w'(next_rand() >> (32 - rob_idx_w));
        p.thread_idx = thread_w'(next_rand() >> (32 - thread_w));
        return p;
    endfunction

    task automatic gen_packets();
        fu_issue_t p;
        // every func and select combination on both alu slots
        for (int i = 0; i < alu_ops; i++) begin
            p         = rand_packet();
            p.func    = alu_func_e'(5'((i / 2) % 10));
            p.opa_sel = opa_sel_e'(2'((i / 20) % 4));
            p.opb_sel = opb_sel_e'(3'((i / 80) % 6));
            pkt_q[i % 2].push_back(p);
        end
        // first 25 walk all pairs of extreme values
        for (int i = 0; i < mult_ops; i++) begin
            p      = rand_packet();
            p.func = alu_func_e'(5'(int'(alu_mul) + i % 4));
            if (i < 25) begin
                p.rs1_value = extremes[i % 5];
                p.rs2_value = extremes[(i / 5) % 5];
            end
            pkt_q[alu_num].push_back(p);
        end
        // six conditions plus a jump over four operand relations
        for (int i = 0; i < br_ops; i++) begin
            p           = rand_packet();
            p.func      = alu_add;
            p.opa_sel   = opa_is_pc;
            p.cond_br   = (i % 7) != 6;
            p.uncond_br = (i % 7) == 6;
            p.opb_sel   = p.uncond_br ? opb_is_j_imm : opb_is_b_imm;
            if (p.cond_br)
                p.inst[14:12] = br_f3[i % 7];
            case ((i / 7) % 4)
                0:       p.rs2_value = p.rs1_value;
                1:       p.rs2_value = p.rs1_value + 32'd1 + (next_rand() & 32'hff);
                2:       p.rs2_value = p.rs1_value - 32'd1 - (next_rand() & 32'hff);
                default: p.rs2_value = p.rs1_value ^ 32'h8000_0000;
            endcase
            pkt_q[alu_num + mult_num].push_back(p);
        end
    endtask

    // capture happens on the edge after valid goes out
    task automatic issue_op(input int s, input fu_issue_t p);
        int waited;
        waited = 0;
        @(posedge clk_i);
        while (!ready_o[s]) begin
            waited++;
            if (waited > wait_limit)
                stop_with_failure($sformatf("timeout: slot %0d never became ready", s));
            @(posedge clk_i);
        end
        p.valid = 1'b1;
        issue_i[s] <= p;
        @(posedge clk_i);
        issue_i[s].valid <= 1'b0;
        cap_q[s].push_back(cyc);
        exp_q[s].push_back(expected_result(p, slot_kind(s)));
    endtask

    task automatic run_slot(input int s);
        for (int i = 0; i < pkt_q[s].size(); i++) begin
            issue_op(s, pkt_q[s][i]);
        end
    endtask

    function automatic bit all_done();
        for (int s = 0; s < slot_num; s++) begin
            if (state[s] != st_idle || rd_idx[s] != exp_q[s].size())
                return 1'b0;
        end
        return 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // compare, hold for a random time, then ack

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            for (int s = 0; s < slot_num; s++) begin
                case (state[s])
                    st_idle: begin
                        if (result_o[s].valid) begin
                            if (rd_idx[s] >= exp_q[s].size())
                                stop_with_failure($sformatf("slot %0d result without issue", s));
                            check_eq(128'(cyc - 1),
                                     128'(cap_q[s][rd_idx[s]] + slot_lat(s) + 1),
                                     $sformatf("slot %0d result latency", s));
                            check_eq(128'(result_o[s]), 128'(exp_q[s][rd_idx[s]]),
                                     $sformatf("slot %0d result packet", s));
                            seen[s]     = result_o[s];
                            rd_idx[s]   = rd_idx[s] + 1;
                            hold_state  = lcg_step(hold_state);
                            hold[s]     = int'(hold_state[31:30]);
                            wait_cnt[s] = 0;
                            state[s]    = st_hold;
                        end else if (rd_idx[s] < exp_q[s].size()) begin
                            wait_cnt[s]++;
                            if (wait_cnt[s] > wait_limit)
                                stop_with_failure($sformatf("timeout: slot %0d gave no result", s));
                        end
                    end
                    st_hold: begin
                        // frozen packet and slot still blocked
                        check_eq(128'(result_o[s]), 128'(seen[s]),
                                 $sformatf("slot %0d held result", s));
                        check_eq(128'(ready_o[s]), 128'(0),
                                 $sformatf("slot %0d ready in hold", s));
                        if (hold[s] == 0) begin
                            ack_i[s] <= 1'b1;
                            state[s] = st_ack;
                        end else begin
                            hold[s]--;
                        end
                    end
                    st_ack: begin
                        ack_i[s] <= 1'b0;
                        state[s] = st_free;
                    end
                    default: begin
                        check_eq(128'(result_o[s].valid), 128'(0),
                                 $sformatf("slot %0d valid after ack", s));
                        check_eq(128'(ready_o[s]), 128'(1),
                                 $sformatf("slot %0d ready after ack", s));
                        state[s] = st_idle;
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int                  waited;
        logic [slot_num-1:0] valids;
        gen_packets();
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        for (int s = 0; s < slot_num; s++) begin
            valids[s] = result_o[s].valid;
        end
        check_eq(128'(ready_o), 128'({slot_num{1'b1}}), "ready after reset");
        check_eq(128'(valids), 128'(0), "valid after reset");
        // all four slots run at once
        fork
            run_slot(0);
            run_slot(1);
            run_slot(2);
            run_slot(3);
        join
        waited = 0;
        while (!all_done()) begin
            waited++;
            if (waited > wait_limit)
                stop_with_failure("timeout: results never drained");
            @(negedge clk_i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- flist.f
hdl/rv_isa_pkg.sv
hdl/fu_pkg.sv
hdl/operand_mux.sv
hdl/alu_core.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/branch_unit.sv
hdl/fu_top.sv
tests/fu_chk.sv
tests/fu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS
FAIL_MSG  ?= ERRORS FOUND

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed"; exit 1; \
	fi; \
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
